// File: Makefile
VERILATOR ?= verilator
TOP       ?= prefetch_tb
FLAGS     ?= --binary --timing --assert -j 0
FILELIST  := prefetch_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module prefetch_top

clean:
	rm -rf $(OBJ_DIR)

// File: prefetch_top.f
src/prefetch_pkg.sv
src/fetch_fifo.sv
src/fetch_ctrl.sv
src/prefetch_cfg.sv
src/prefetch_top.sv
tb/instr_mem_model.sv
tb/prefetch_tb.sv

// File: src/fetch_ctrl.sv
/*
 * Fetch controller
 * Issues sequential word fetches, tracks outstanding requests and drops stale responses
 */
`timescale 1ns/1ns

module fetch_ctrl #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             enable_i,
  input  logic [prefetch_pkg::ADDR_W-1:0]  boot_addr_i,
  input  logic                             redirect_i,
  input  logic [prefetch_pkg::ADDR_W-1:0]  redirect_addr_i,
  output logic                             instr_req_o,
  output logic [prefetch_pkg::ADDR_W-1:0]  instr_addr_o,
  input  logic                             instr_gnt_i,
  input  logic                             instr_rvalid_i,
  input  logic                             instr_err_i,
  input  logic [$clog2(FifoDepth+1)-1:0]   rsp_count_i,
  output logic                             addr_push_o,
  output logic                             addr_pop_o,
  output logic                             rsp_push_o,
  output logic                             flush_o,
  output logic                             err_seen_o
);

  import prefetch_pkg::*;

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic              req_q;
  logic              req_d;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] next_q;
  logic [ADDR_W-1:0] next_d;
  logic              en_q;
  logic              en_rise;
  logic              stale_q;
  logic              stale_d;
  logic [CntW-1:0]   outst_q;
  logic [CntW-1:0]   outst_d;
  logic [CntW-1:0]   discard_q;
  logic [CntW-1:0]   discard_d;
  logic [CntW:0]     occ_sum;
  logic              gnt_fire;
  logic              rsp_drop;
  logic              keep;
  logic              room;
  logic              launch;

  assign gnt_fire = req_q & instr_gnt_i;
  assign en_rise  = enable_i & ~en_q;

  // Words in flight plus words waiting for the consumer
  assign occ_sum = (CntW+1)'(outst_q) + (CntW+1)'(rsp_count_i) + (CntW+1)'(gnt_fire);
  assign room    = occ_sum < (CntW+1)'(FifoDepth);

  // A new request waits one cycle after a restart so it picks up the new address
  assign launch = (~req_q | gnt_fire) & enable_i & room & ~redirect_i & ~en_rise;

  // Responses older than the last redirect are thrown away
  assign rsp_drop = instr_rvalid_i & (discard_q != '0);
  assign keep     = instr_rvalid_i & (discard_q == '0) & ~redirect_i;

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;
  assign addr_push_o  = gnt_fire & ~stale_q & ~redirect_i;
  assign addr_pop_o   = keep;
  assign rsp_push_o   = keep;
  assign err_seen_o   = keep & instr_err_i;
  assign flush_o      = redirect_i;

  always_comb begin
    outst_d = outst_q + CntW'(gnt_fire) - CntW'(instr_rvalid_i);

    if (redirect_i) begin
      // Everything still owed by the bus after this cycle is stale
      discard_d = outst_d;
    end else begin
      discard_d = discard_q - CntW'(rsp_drop) + CntW'(gnt_fire & stale_q);
    end

    // Request caught by a redirect before its grant
    stale_d = stale_q;
    if (gnt_fire) begin
      stale_d = 1'b0;
    end
    if (redirect_i && req_q && !instr_gnt_i) begin
      stale_d = 1'b1;
    end

    req_d = req_q;
    if (!req_q || gnt_fire) begin
      req_d = launch;
    end

    next_d = next_q;
    if (redirect_i) begin
      next_d = redirect_addr_i;
    end else if (en_rise) begin
      next_d = boot_addr_i;
    end else if (launch) begin
      next_d = next_q + ADDR_W'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q     <= 1'b0;
      next_q    <= '0;
      en_q      <= 1'b0;
      stale_q   <= 1'b0;
      outst_q   <= '0;
      discard_q <= '0;
    end else begin
      req_q     <= req_d;
      next_q    <= next_d;
      en_q      <= enable_i;
      stale_q   <= stale_d;
      outst_q   <= outst_d;
      discard_q <= discard_d;
    end
  end

  // Bus address of the current request
  always_ff @(posedge clk_i) begin
    if (launch) begin
      addr_q <= next_q;
    end
  end

  a_addr_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o)
  );

  a_rsp_expected: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    instr_rvalid_i |-> outst_q != '0
  );

endmodule

// File: src/fetch_fifo.sv
/*
 * Fetch FIFO
 * Circular buffer with a generic payload type and a single-cycle flush
 */
`timescale 1ns/1ns

module fetch_fifo #(
  parameter int unsigned FifoDepth = 4,
  parameter type         T         = logic [31:0]
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           flush_i,
  input  logic                           push_i,
  input  T                               push_data_i,
  input  logic                           pop_i,
  output T                               pop_data_o,
  output logic                           empty_o,
  output logic                           full_o,
  output logic [$clog2(FifoDepth+1)-1:0] count_o
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  T              mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  // Flush wins over any push or pop in the same cycle
  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & ~flush_i;

  assign pop_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == CntW'(FifoDepth));
  assign count_o    = count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Callers must respect the full and empty flags
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push_i && !flush_i |-> !full_o || pop_i
  );

  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pop_i && !flush_i |-> !empty_o
  );

endmodule

// File: src/prefetch_cfg.sv
/*
 * Prefetch configuration registers
 * Fetch enable, boot address and a saturating count of fetch errors
 */
`timescale 1ns/1ns

module prefetch_cfg (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            cfg_we_i,
  input  logic [1:0]                      cfg_addr_i,
  input  logic [prefetch_pkg::DATA_W-1:0] cfg_wdata_i,
  output logic [prefetch_pkg::DATA_W-1:0] cfg_rdata_o,
  input  logic                            err_seen_i,
  output logic                            enable_o,
  output logic [prefetch_pkg::ADDR_W-1:0] boot_addr_o
);

  import prefetch_pkg::*;

  localparam int unsigned ErrCntW = 16;

  logic               en_q;
  logic [ADDR_W-1:0]  boot_q;
  logic [ErrCntW-1:0] err_cnt_q;
  logic               err_cnt_max;

  assign err_cnt_max = &err_cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q      <= 1'b0;
      boot_q    <= '0;
      err_cnt_q <= '0;
    end else begin
      if (cfg_we_i && cfg_addr_i == CFG_CTRL) begin
        en_q <= cfg_wdata_i[0];
      end
      // Fetches are word aligned
      if (cfg_we_i && cfg_addr_i == CFG_BOOT) begin
        boot_q <= {cfg_wdata_i[ADDR_W-1:2], 2'b00};
      end
      // Any write clears the counter, whatever the data
      if (cfg_we_i && cfg_addr_i == CFG_ERRCNT) begin
        err_cnt_q <= '0;
      end else if (err_seen_i && !err_cnt_max) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      CFG_CTRL:   cfg_rdata_o = {{(DATA_W-1){1'b0}}, en_q};
      CFG_BOOT:   cfg_rdata_o = boot_q;
      CFG_ERRCNT: cfg_rdata_o = {{(DATA_W-ErrCntW){1'b0}}, err_cnt_q};
      default:    cfg_rdata_o = '0;
    endcase
  end

  assign enable_o    = en_q;
  assign boot_addr_o = boot_q;

endmodule

// File: src/prefetch_pkg.sv
/*
 * Instruction prefetch shared definitions
 * Bus widths, configuration register map and the buffered fetch entry
 */
package prefetch_pkg;

  // Byte address and instruction word widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Configuration register offsets
  localparam logic [1:0] CFG_CTRL   = 2'd0;
  localparam logic [1:0] CFG_BOOT   = 2'd1;
  localparam logic [1:0] CFG_ERRCNT = 2'd2;

  // One fetched word as seen by the consumer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    logic              err;
  } fetch_entry_t;

endpackage

// File: src/prefetch_top.sv
/*
 * Instruction prefetch top level
 * Configuration block, fetch controller, address FIFO and response FIFO
 */
`timescale 1ns/1ns

module prefetch_top #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            cfg_we_i,
  input  logic [1:0]                      cfg_addr_i,
  input  logic [prefetch_pkg::DATA_W-1:0] cfg_wdata_i,
  output logic [prefetch_pkg::DATA_W-1:0] cfg_rdata_o,
  input  logic                            redirect_i,
  input  logic [prefetch_pkg::ADDR_W-1:0] redirect_addr_i,
  output logic                            instr_req_o,
  output logic [prefetch_pkg::ADDR_W-1:0] instr_addr_o,
  input  logic                            instr_gnt_i,
  input  logic                            instr_rvalid_i,
  input  logic [prefetch_pkg::DATA_W-1:0] instr_rdata_i,
  input  logic                            instr_err_i,
  output logic                            fetch_valid_o,
  input  logic                            fetch_ready_i,
  output logic [prefetch_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic [prefetch_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic                            fetch_err_o
);

  import prefetch_pkg::*;

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic              enable;
  logic [ADDR_W-1:0] boot_addr;
  logic              err_seen;
  logic              flush;
  logic              addr_push;
  logic              addr_pop;
  logic [ADDR_W-1:0] addr_head;
  logic              rsp_push;
  logic              rsp_pop;
  logic              rsp_empty;
  logic [CntW-1:0]   rsp_count;
  fetch_entry_t      rsp_entry;
  fetch_entry_t      head_entry;

  // Response joined with the address it was fetched from
  assign rsp_entry.addr  = addr_head;
  assign rsp_entry.rdata = instr_rdata_i;
  assign rsp_entry.err   = instr_err_i;

  assign fetch_valid_o = ~rsp_empty;
  assign rsp_pop       = fetch_ready_i & ~rsp_empty;
  assign fetch_addr_o  = head_entry.addr;
  assign fetch_rdata_o = head_entry.rdata;
  assign fetch_err_o   = head_entry.err;

  prefetch_cfg u_cfg (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .cfg_we_i    (cfg_we_i   ),
    .cfg_addr_i  (cfg_addr_i ),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .err_seen_i  (err_seen   ),
    .enable_o    (enable     ),
    .boot_addr_o (boot_addr  )
  );

  fetch_ctrl #(
    .FifoDepth (FifoDepth)
  ) u_ctrl (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .enable_i        (enable         ),
    .boot_addr_i     (boot_addr      ),
    .redirect_i      (redirect_i     ),
    .redirect_addr_i (redirect_addr_i),
    .instr_req_o     (instr_req_o    ),
    .instr_addr_o    (instr_addr_o   ),
    .instr_gnt_i     (instr_gnt_i    ),
    .instr_rvalid_i  (instr_rvalid_i ),
    .instr_err_i     (instr_err_i    ),
    .rsp_count_i     (rsp_count      ),
    .addr_push_o     (addr_push      ),
    .addr_pop_o      (addr_pop       ),
    .rsp_push_o      (rsp_push       ),
    .flush_o         (flush          ),
    .err_seen_o      (err_seen       )
  );

  // Addresses of granted requests, in bus order
  fetch_fifo #(
    .FifoDepth (FifoDepth         ),
    .T         (logic [ADDR_W-1:0])
  ) u_addr_fifo (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .flush_i     (flush       ),
    .push_i      (addr_push   ),
    .push_data_i (instr_addr_o),
    .pop_i       (addr_pop    ),
    .pop_data_o  (addr_head   ),
    .empty_o     (            ),
    .full_o      (            ),
    .count_o     (            )
  );

  fetch_fifo #(
    .FifoDepth (FifoDepth    ),
    .T         (fetch_entry_t)
  ) u_rsp_fifo (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .flush_i     (flush     ),
    .push_i      (rsp_push  ),
    .push_data_i (rsp_entry ),
    .pop_i       (rsp_pop   ),
    .pop_data_o  (head_entry),
    .empty_o     (rsp_empty ),
    .full_o      (          ),
    .count_o     (rsp_count )
  );

endmodule

// File: tb/instr_mem_model.sv
/*
 * Instruction memory model
 * Random grant delay and in-order responses computed from the address
 */
`timescale 1ns/1ns

module instr_mem_model #(
  parameter logic [31:0] Seed = 32'h22c7_8ff8
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            req_i,
  input  logic [prefetch_pkg::ADDR_W-1:0] addr_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output logic [prefetch_pkg::DATA_W-1:0] rdata_o,
  output logic                            err_o
);

  import prefetch_pkg::*;

  logic [ADDR_W-1:0] addr_q [$];
  int unsigned       due_q [$];
  logic [ADDR_W-1:0] rsp_addr;
  int unsigned       cycle;
  int unsigned       gnt_wait;
  int unsigned       last_due;
  int unsigned       due;

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    cycle    = 0;
    last_due = 0;
    void'($urandom(Seed));
    gnt_wait = $urandom_range(3, 0);
    forever begin
      @(posedge clk_i);
      #1;
      cycle++;
      if (!rst_n_i) begin
        addr_q.delete();
        due_q.delete();
        gnt_o    = 1'b0;
        rvalid_o = 1'b0;
      end else begin
        // Oldest granted address answers first
        rvalid_o = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
          rsp_addr = addr_q.pop_front();
          void'(due_q.pop_front());
          rvalid_o = 1'b1;
          rdata_o  = rsp_addr ^ 32'hA5A5_0000;
          err_o    = (rsp_addr[7:4] == 4'hF);
        end
        gnt_o = 1'b0;
        if (req_i && gnt_wait == 0) begin
          gnt_o = 1'b1;
          addr_q.push_back(addr_i);
          // 1 to 3 cycles after the grant, never ahead of an older response
          due = cycle + $urandom_range(3, 1);
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          due_q.push_back(due);
          gnt_wait = $urandom_range(3, 0);
        end else if (req_i) begin
          gnt_wait--;
        end
      end
    end
  end

endmodule

// File: tb/prefetch_tb.sv
/*
 * Instruction prefetch testbench
 * Directed tests for fetch order, back-pressure, redirect, errors and disable
 */
`timescale 1ns/1ns

module prefetch_tb;

  import prefetch_pkg::*;

  localparam int unsigned FifoDepth = 4;
  localparam int unsigned Timeout   = 200;
  localparam logic [31:0] RandSeed  = 32'h22c7_8ff8;

  logic              clk;
  logic              rst_n;
  logic              cfg_we;
  logic [1:0]        cfg_addr;
  logic [DATA_W-1:0] cfg_wdata;
  logic [DATA_W-1:0] cfg_rdata;
  logic              redirect;
  logic [ADDR_W-1:0] redirect_addr;
  logic              instr_req;
  logic [ADDR_W-1:0] instr_addr;
  logic              instr_gnt;
  logic              instr_rvalid;
  logic [DATA_W-1:0] instr_rdata;
  logic              instr_err;
  logic              fetch_valid;
  logic              fetch_ready;
  logic [ADDR_W-1:0] fetch_addr;
  logic [DATA_W-1:0] fetch_rdata;
  logic              fetch_err;

  int unsigned       grant_cnt = 0;
  int unsigned       rsp_cnt   = 0;
  int unsigned       taken_cnt = 0;
  int unsigned       err_words = 0;
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] rd;

  prefetch_top #(
    .FifoDepth (FifoDepth)
  ) DUT (
    .clk_i           (clk          ),
    .rst_n_i         (rst_n        ),
    .cfg_we_i        (cfg_we       ),
    .cfg_addr_i      (cfg_addr     ),
    .cfg_wdata_i     (cfg_wdata    ),
    .cfg_rdata_o     (cfg_rdata    ),
    .redirect_i      (redirect     ),
    .redirect_addr_i (redirect_addr),
    .instr_req_o     (instr_req    ),
    .instr_addr_o    (instr_addr   ),
    .instr_gnt_i     (instr_gnt    ),
    .instr_rvalid_i  (instr_rvalid ),
    .instr_rdata_i   (instr_rdata  ),
    .instr_err_i     (instr_err    ),
    .fetch_valid_o   (fetch_valid  ),
    .fetch_ready_i   (fetch_ready  ),
    .fetch_addr_o    (fetch_addr   ),
    .fetch_rdata_o   (fetch_rdata  ),
    .fetch_err_o     (fetch_err    )
  );

  instr_mem_model #(
    .Seed (RandSeed)
  ) u_mem (
    .clk_i    (clk         ),
    .rst_n_i  (rst_n       ),
    .req_i    (instr_req   ),
    .addr_i   (instr_addr  ),
    .gnt_o    (instr_gnt   ),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata ),
    .err_o    (instr_err   )
  );

  always #20 clk = ~clk;

  // Bus traffic seen at each rising edge
  always @(posedge clk) begin
    if (instr_req && instr_gnt) begin
      grant_cnt++;
    end
    if (instr_rvalid) begin
      rsp_cnt++;
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int unsigned got,
                             input int unsigned exp);
    if (got != exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // Memory contents and error map of the test system
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic logic in_err_region(input logic [ADDR_W-1:0] addr);
    return addr[7:4] == 4'hF;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [DATA_W-1:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    step();
    cfg_we    = 1'b0;
  endtask

  task automatic cfg_read(input logic [1:0] addr, output logic [DATA_W-1:0] data);
    cfg_addr = addr;
    #1;
    data = cfg_rdata;
  endtask

  task automatic send_redirect(input logic [ADDR_W-1:0] addr);
    redirect_addr = addr;
    redirect      = 1'b1;
    step();
    redirect      = 1'b0;
    exp_addr      = addr;
  endtask

  // Consume one word and compare it with the next expected address
  task automatic take_word();
    int unsigned n;
    n = 0;
    fetch_ready = 1'b1;
    while (!fetch_valid) begin
      step();
      n++;
      if (n > Timeout) begin
        stop_run("timeout waiting for a fetched word");
      end
    end
    check_addr("fetch_addr_o", fetch_addr, exp_addr);
    check_data("fetch_rdata_o", fetch_rdata, mem_word(exp_addr));
    check_bit("fetch_err_o", fetch_err, in_err_region(exp_addr));
    if (in_err_region(exp_addr)) begin
      err_words++;
    end
    exp_addr = exp_addr + 32'd4;
    taken_cnt++;
    step();
    fetch_ready = 1'b0;
  endtask

  task automatic wait_req_high();
    int unsigned n;
    n = 0;
    while (!instr_req) begin
      step();
      n++;
      if (n > Timeout) begin
        stop_run("timeout waiting for a fetch request");
      end
    end
  endtask

  task automatic wait_req_low();
    int unsigned n;
    n = 0;
    while (instr_req) begin
      step();
      n++;
      if (n > Timeout) begin
        stop_run("timeout waiting for the request line to drop");
      end
    end
  endtask

  task automatic wait_bus_idle();
    int unsigned n;
    n = 0;
    while (grant_cnt != rsp_cnt) begin
      step();
      n++;
      if (n > Timeout) begin
        stop_run("timeout waiting for outstanding responses");
      end
    end
  endtask

  task automatic test_reset_values();
    check_bit("instr_req_o", instr_req, 1'b0);
    check_bit("fetch_valid_o", fetch_valid, 1'b0);
    cfg_read(CFG_CTRL, rd);
    check_data("cfg_rdata_o", rd, '0);
    cfg_read(CFG_BOOT, rd);
    check_data("cfg_rdata_o", rd, '0);
    cfg_read(CFG_ERRCNT, rd);
    check_data("cfg_rdata_o", rd, '0);
  endtask

  task automatic test_sequential();
    // Low address bits are dropped by the boot register
    cfg_write(CFG_BOOT, 32'h0000_1003);
    cfg_read(CFG_BOOT, rd);
    check_data("cfg_rdata_o", rd, 32'h0000_1000);
    cfg_write(CFG_CTRL, 32'd1);
    // First request after enable goes to the boot address
    wait_req_high();
    check_addr("instr_addr_o", instr_addr, 32'h0000_1000);
    exp_addr = 32'h0000_1000;
    repeat (16) take_word();
  endtask

  task automatic test_back_pressure();
    step();
    wait_req_low();
    repeat (3) begin
      step();
      check_bit("instr_req_o", instr_req, 1'b0);
    end
    check_count("words granted but not consumed", grant_cnt - taken_cnt, FifoDepth);
    repeat (FifoDepth + 4) take_word();
  endtask

  task automatic test_redirect();
    repeat (2) take_word();
    send_redirect(32'h0000_2000);
    repeat (6) take_word();
  endtask

  task automatic test_errors();
    cfg_write(CFG_ERRCNT, 32'd0);
    err_words = 0;
    send_redirect(32'h0000_30E0);
    repeat (12) take_word();
    cfg_read(CFG_ERRCNT, rd);
    check_data("cfg_rdata_o", rd, err_words);
    cfg_write(CFG_ERRCNT, 32'hFFFF_FFFF);
    cfg_read(CFG_ERRCNT, rd);
    check_data("cfg_rdata_o", rd, '0);
  endtask

  task automatic test_disable();
    cfg_write(CFG_CTRL, 32'd0);
    wait_req_low();
    wait_bus_idle();
    // Words already in flight still arrive in order
    while (fetch_valid) begin
      take_word();
    end
    repeat (8) begin
      step();
      check_bit("instr_req_o", instr_req, 1'b0);
      check_bit("fetch_valid_o", fetch_valid, 1'b0);
    end
    cfg_write(CFG_BOOT, 32'h0000_4000);
    cfg_write(CFG_CTRL, 32'd1);
    wait_req_high();
    check_addr("instr_addr_o", instr_addr, 32'h0000_4000);
    exp_addr = 32'h0000_4000;
    repeat (4) take_word();
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = '0;
    cfg_wdata     = '0;
    redirect      = 1'b0;
    redirect_addr = '0;
    fetch_ready   = 1'b0;
    exp_addr      = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    test_reset_values();
    test_sequential();
    test_back_pressure();
    test_redirect();
    test_errors();
    test_disable();
    $display("All tests passed");
    $finish;
  end

endmodule
